/* verilog/ssb_demod_pkg.sv */
package ssb_demod_pkg;

    // sample format
    localparam int SAMPLE_W = 16;
    localparam int SSB_SYMBOLS = 4;

    // minimum spacing of valid input samples, in clock cycles
    localparam int IN_GAP = 6;

    // unit magnitude of the twiddle factors, Q1.15
    localparam int TW_ONE = 2 ** (SAMPLE_W - 1) - 1;

    // real part in the upper half of the word
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    // one stream beat, first marks window start or bin 0
    typedef struct packed {
        logic  first;
        cplx_t data;
    } sym_beat_t;

    typedef struct packed {
        logic pbch_start;
        logic pbch_valid;
        logic sss_start;
        logic sss_valid;
        logic symbol_start;
    } ssb_flags_t;

    typedef enum logic [1:0] {
        CP_IDLE,
        CP_SKIP,
        CP_WINDOW
    } cp_state_e;

    typedef enum logic [1:0] {
        FFT_IDLE,
        FFT_COMPUTE,
        FFT_DRAIN
    } fft_state_e;

    typedef enum logic [1:0] {
        TAG_IDLE,
        TAG_WAIT,
        TAG_SYMBOL
    } tag_state_e;

    // forward transform coefficient exp(-j*2*pi*idx/len)
    function automatic cplx_t twiddle(input int idx, input int len);
        real   ang;
        cplx_t w;
        ang  = -2.0 * 3.14159265358979 * real'(idx) / real'(len);
        w.re = SAMPLE_W'(int'($cos(ang) * real'(TW_ONE)));
        w.im = SAMPLE_W'(int'($sin(ang) * real'(TW_ONE)));
        return w;
    endfunction

endpackage

/* verilog/cp_remover.sv */
`timescale 1ns/10ps

module cp_remover #(
    parameter int NFFT   = 8,
    parameter int CP_LEN = 18
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     ssb_start_i,
    input  ssb_demod_pkg::cplx_t     in_data_i,
    input  logic                     in_valid_i,
    output ssb_demod_pkg::sym_beat_t win_beat_o,
    output logic                     win_valid_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CNT_W = $clog2((FFT_LEN > CP_LEN) ? FFT_LEN : CP_LEN);
    localparam int SYM_W = $clog2(ssb_demod_pkg::SSB_SYMBOLS);

    ssb_demod_pkg::cp_state_e state_q;
    logic [CNT_W-1:0]         samp_cnt_q;
    logic [SYM_W-1:0]         sym_cnt_q;
    logic                     open_now;
    logic                     in_window;

    // first symbol has no prefix, the pulse opens its window directly
    always_comb begin
        open_now  = (state_q == ssb_demod_pkg::CP_IDLE) && ssb_start_i;
        in_window = open_now || (state_q == ssb_demod_pkg::CP_WINDOW);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= ssb_demod_pkg::CP_IDLE;
            samp_cnt_q <= '0;
            sym_cnt_q  <= '0;
        end else begin
            case (state_q)
                ssb_demod_pkg::CP_IDLE: begin
                    if (ssb_start_i) begin
                        state_q    <= ssb_demod_pkg::CP_WINDOW;
                        sym_cnt_q  <= '0;
                        samp_cnt_q <= in_valid_i ? CNT_W'(1) : '0;
                    end
                end
                ssb_demod_pkg::CP_WINDOW: begin
                    if (in_valid_i) begin
                        if (samp_cnt_q == CNT_W'(FFT_LEN - 1)) begin
                            samp_cnt_q <= '0;
                            if (sym_cnt_q == SYM_W'(ssb_demod_pkg::SSB_SYMBOLS - 1)) begin
                                state_q <= ssb_demod_pkg::CP_IDLE;
                            end else begin
                                sym_cnt_q <= sym_cnt_q + 1'b1;
                                state_q   <= ssb_demod_pkg::CP_SKIP;
                            end
                        end else begin
                            samp_cnt_q <= samp_cnt_q + 1'b1;
                        end
                    end
                end
                ssb_demod_pkg::CP_SKIP: begin
                    if (in_valid_i) begin
                        if (samp_cnt_q == CNT_W'(CP_LEN - 1)) begin
                            samp_cnt_q <= '0;
                            state_q    <= ssb_demod_pkg::CP_WINDOW;
                        end else begin
                            samp_cnt_q <= samp_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= ssb_demod_pkg::CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= in_valid_i && in_window;
        end
    end

    always_ff @(posedge clk_i) begin
        win_beat_o.data  <= in_data_i;
        win_beat_o.first <= open_now || (samp_cnt_q == '0);
    end

    // the fft needs this gap to keep up with the window rate
    input_pacing: assert property (@(posedge clk_i) disable iff (!reset_ni)
        in_valid_i |=> !in_valid_i [*(ssb_demod_pkg::IN_GAP - 1)])
        else $error("cp_remover: input valid closer than %0d cycles", ssb_demod_pkg::IN_GAP);

endmodule

/* verilog/fft_butterfly.sv */
`timescale 1ns/10ps

module fft_butterfly (
    input  logic                 clk_i,
    input  ssb_demod_pkg::cplx_t a_i,
    input  ssb_demod_pkg::cplx_t b_i,
    input  ssb_demod_pkg::cplx_t w_i,
    input  logic                 valid_i,
    output ssb_demod_pkg::cplx_t x_o,
    output ssb_demod_pkg::cplx_t y_o,
    output logic                 valid_o
);

    localparam int W  = ssb_demod_pkg::SAMPLE_W;
    localparam int PW = 2 * W + 1;
    localparam int TW = W + 2;

    logic signed [PW-1:0] prod_re;
    logic signed [PW-1:0] prod_im;
    logic signed [TW-1:0] t_re;
    logic signed [TW-1:0] t_im;
    ssb_demod_pkg::cplx_t a_q;
    logic signed [TW-1:0] t_re_q;
    logic signed [TW-1:0] t_im_q;
    logic                 valid_q;
    logic signed [TW:0]   sum_re;
    logic signed [TW:0]   sum_im;
    logic signed [TW:0]   dif_re;
    logic signed [TW:0]   dif_im;

    // t = b * w, back to sample scale with rounding
    always_comb begin
        prod_re = b_i.re * w_i.re - b_i.im * w_i.im;
        prod_im = b_i.re * w_i.im + b_i.im * w_i.re;
        t_re = TW'((prod_re + PW'(1 << (W - 2))) >>> (W - 1));
        t_im = TW'((prod_im + PW'(1 << (W - 2))) >>> (W - 1));
    end

    always_ff @(posedge clk_i) begin
        a_q     <= a_i;
        t_re_q  <= t_re;
        t_im_q  <= t_im;
        valid_q <= valid_i;
    end

    always_comb begin
        sum_re = a_q.re + t_re_q;
        sum_im = a_q.im + t_im_q;
        dif_re = a_q.re - t_re_q;
        dif_im = a_q.im - t_im_q;
    end

    // halve each result, round half up
    always_ff @(posedge clk_i) begin
        x_o.re  <= W'((sum_re + (TW + 1)'(1)) >>> 1);
        x_o.im  <= W'((sum_im + (TW + 1)'(1)) >>> 1);
        y_o.re  <= W'((dif_re + (TW + 1)'(1)) >>> 1);
        y_o.im  <= W'((dif_im + (TW + 1)'(1)) >>> 1);
        valid_o <= valid_q;
    end

endmodule

/* verilog/fft_core.sv */
`timescale 1ns/10ps

module fft_core #(
    parameter int NFFT = 8
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  ssb_demod_pkg::sym_beat_t win_beat_i,
    input  logic                     win_valid_i,
    output ssb_demod_pkg::sym_beat_t bin_beat_o,
    output logic                     bin_valid_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int HALF = FFT_LEN / 2;
    localparam int STG_W = $clog2(NFFT);
    // idle slots after a stage so its last write lands before the next read
    localparam int FLUSH = 2;

    // two banks, bank select is the top address bit
    ssb_demod_pkg::cplx_t mem [2*FFT_LEN];
    ssb_demod_pkg::cplx_t tw_rom [HALF];

    ssb_demod_pkg::fft_state_e state_q;
    logic                      fill_bank_q;
    logic                      comp_bank_q;
    logic [NFFT-1:0]           fill_cnt_q;
    logic [NFFT-1:0]           step_q;
    logic [STG_W-1:0]          stage_q;

    logic [NFFT-1:0]           wr_idx;
    logic [NFFT-1:0]           wr_addr;
    logic                      bank_full;
    logic [NFFT-2:0]           pair;
    logic [NFFT-1:0]           pos;
    logic [NFFT-1:0]           addr_a;
    logic [NFFT-1:0]           addr_b;
    logic [NFFT-2:0]           tw_idx;
    logic                      issue;
    logic [1:0][NFFT-1:0]      wa_q;
    logic [1:0][NFFT-1:0]      wb_q;
    ssb_demod_pkg::cplx_t      bf_x;
    ssb_demod_pkg::cplx_t      bf_y;
    logic                      bf_valid;

    for (genvar k = 0; k < HALF; k++) begin : g_twiddle
        assign tw_rom[k] = ssb_demod_pkg::twiddle(k, FFT_LEN);
    end

    // window start realigns the fill counter
    always_comb begin
        wr_idx    = win_beat_i.first ? '0 : fill_cnt_q;
        wr_addr   = {<<{wr_idx}};
        bank_full = win_valid_i && (wr_idx == NFFT'(FFT_LEN - 1));
    end

    // in-place DIT addressing: a zero bit inserted at the stage position
    always_comb begin
        pair   = step_q[NFFT-2:0];
        pos    = NFFT'(pair) & ((NFFT'(1) << stage_q) - NFFT'(1));
        addr_a = ((NFFT'(pair) >> stage_q) << (stage_q + 1)) | pos;
        addr_b = addr_a | (NFFT'(1) << stage_q);
        tw_idx = (NFFT - 1)'(pos << (NFFT - 1 - stage_q));
        issue  = (state_q == ssb_demod_pkg::FFT_COMPUTE) && (step_q < NFFT'(HALF));
    end

    fft_butterfly u_butterfly (
        .clk_i   (clk_i),
        .a_i     (mem[{comp_bank_q, addr_a}]),
        .b_i     (mem[{comp_bank_q, addr_b}]),
        .w_i     (tw_rom[tw_idx]),
        .valid_i (issue),
        .x_o     (bf_x),
        .y_o     (bf_y),
        .valid_o (bf_valid)
    );

    // write-back addresses follow the butterfly latency
    always_ff @(posedge clk_i) begin
        wa_q[0] <= addr_a;
        wa_q[1] <= wa_q[0];
        wb_q[0] <= addr_b;
        wb_q[1] <= wb_q[0];
    end

    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            mem[{fill_bank_q, wr_addr}] <= win_beat_i.data;
        end
        if (bf_valid) begin
            mem[{comp_bank_q, wa_q[1]}] <= bf_x;
            mem[{comp_bank_q, wb_q[1]}] <= bf_y;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= ssb_demod_pkg::FFT_IDLE;
            fill_bank_q <= 1'b0;
            comp_bank_q <= 1'b0;
            fill_cnt_q  <= '0;
            step_q      <= '0;
            stage_q     <= '0;
        end else begin
            if (win_valid_i) begin
                fill_cnt_q <= wr_idx + 1'b1;
                if (bank_full) begin
                    fill_bank_q <= !fill_bank_q;
                end
            end
            case (state_q)
                ssb_demod_pkg::FFT_IDLE: begin
                    if (bank_full) begin
                        comp_bank_q <= fill_bank_q;
                        step_q      <= '0;
                        stage_q     <= '0;
                        state_q     <= ssb_demod_pkg::FFT_COMPUTE;
                    end
                end
                ssb_demod_pkg::FFT_COMPUTE: begin
                    if (step_q == NFFT'(HALF + FLUSH - 1)) begin
                        step_q <= '0;
                        if (stage_q == STG_W'(NFFT - 1)) begin
                            state_q <= ssb_demod_pkg::FFT_DRAIN;
                        end else begin
                            stage_q <= stage_q + 1'b1;
                        end
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                ssb_demod_pkg::FFT_DRAIN: begin
                    if (step_q == NFFT'(FFT_LEN - 1)) begin
                        step_q  <= '0;
                        state_q <= ssb_demod_pkg::FFT_IDLE;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: state_q <= ssb_demod_pkg::FFT_IDLE;
            endcase
        end
    end

    // bins leave in natural order on consecutive cycles
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bin_valid_o <= 1'b0;
        end else begin
            bin_valid_o <= (state_q == ssb_demod_pkg::FFT_DRAIN);
        end
    end

    always_ff @(posedge clk_i) begin
        bin_beat_o.first <= (step_q == '0);
        bin_beat_o.data  <= mem[{comp_bank_q, step_q}];
    end

    bank_overrun: assert property (@(posedge clk_i) disable iff (!reset_ni)
        bank_full |-> state_q == ssb_demod_pkg::FFT_IDLE)
        else $error("fft_core: window complete while previous symbol still in progress");

endmodule

/* verilog/symbol_tagger.sv */
`timescale 1ns/10ps

module symbol_tagger #(
    parameter int NFFT = 8
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      ssb_start_i,
    input  ssb_demod_pkg::sym_beat_t  bin_beat_i,
    input  logic                      bin_valid_i,
    output ssb_demod_pkg::cplx_t      out_data_o,
    output logic                      out_valid_o,
    output ssb_demod_pkg::ssb_flags_t flags_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int SYM_W = $clog2(ssb_demod_pkg::SSB_SYMBOLS);

    ssb_demod_pkg::tag_state_e state_q;
    logic [NFFT-1:0]           bin_cnt_q;
    logic [SYM_W-1:0]          sym_cnt_q;
    logic                      tagging;
    logic                      sym_first;

    always_comb begin
        sym_first = bin_valid_i && bin_beat_i.first && (state_q == ssb_demod_pkg::TAG_WAIT);
        tagging   = sym_first || (bin_valid_i && (state_q == ssb_demod_pkg::TAG_SYMBOL));
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= ssb_demod_pkg::TAG_IDLE;
            bin_cnt_q <= '0;
            sym_cnt_q <= '0;
        end else begin
            case (state_q)
                ssb_demod_pkg::TAG_IDLE: begin
                    if (ssb_start_i) begin
                        sym_cnt_q <= '0;
                        state_q   <= ssb_demod_pkg::TAG_WAIT;
                    end
                end
                ssb_demod_pkg::TAG_WAIT: begin
                    if (sym_first) begin
                        bin_cnt_q <= NFFT'(1);
                        state_q   <= ssb_demod_pkg::TAG_SYMBOL;
                    end
                end
                ssb_demod_pkg::TAG_SYMBOL: begin
                    if (bin_valid_i) begin
                        if (bin_cnt_q == NFFT'(FFT_LEN - 1)) begin
                            bin_cnt_q <= '0;
                            if (sym_cnt_q == SYM_W'(ssb_demod_pkg::SSB_SYMBOLS - 1)) begin
                                state_q <= ssb_demod_pkg::TAG_IDLE;
                            end else begin
                                sym_cnt_q <= sym_cnt_q + 1'b1;
                                state_q   <= ssb_demod_pkg::TAG_WAIT;
                            end
                        end else begin
                            bin_cnt_q <= bin_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= ssb_demod_pkg::TAG_IDLE;
            endcase
        end
    end

    // symbol 0 is PBCH, symbol 1 is SSS
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o <= 1'b0;
            flags_o     <= '0;
        end else begin
            out_valid_o          <= bin_valid_i;
            flags_o.symbol_start <= sym_first;
            flags_o.pbch_start   <= sym_first && (sym_cnt_q == SYM_W'(0));
            flags_o.pbch_valid   <= tagging && (sym_cnt_q == SYM_W'(0));
            flags_o.sss_start    <= sym_first && (sym_cnt_q == SYM_W'(1));
            flags_o.sss_valid    <= tagging && (sym_cnt_q == SYM_W'(1));
        end
    end

    always_ff @(posedge clk_i) begin
        out_data_o <= bin_beat_i.data;
    end

    // fft drain must deliver a symbol without gaps
    bins_contiguous: assert property (@(posedge clk_i) disable iff (!reset_ni)
        state_q == ssb_demod_pkg::TAG_SYMBOL |-> bin_valid_i)
        else $error("symbol_tagger: gap inside a symbol's bin run");

endmodule

/* verilog/ssb_demod_top.sv */
`timescale 1ns/10ps

module ssb_demod_top #(
    parameter int NFFT   = 8,
    parameter int CP_LEN = 18
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  ssb_demod_pkg::cplx_t      s_axis_in_tdata_i,
    input  logic                      s_axis_in_tvalid_i,
    input  logic                      ssb_start_i,
    output ssb_demod_pkg::cplx_t      m_axis_out_tdata_o,
    output logic                      m_axis_out_tvalid_o,
    output ssb_demod_pkg::ssb_flags_t flags_o
);

    ssb_demod_pkg::sym_beat_t win_beat;
    logic                     win_valid;
    ssb_demod_pkg::sym_beat_t bin_beat;
    logic                     bin_valid;

    cp_remover #(
        .NFFT   (NFFT),
        .CP_LEN (CP_LEN)
    ) u_cp_remover (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .ssb_start_i (ssb_start_i),
        .in_data_i   (s_axis_in_tdata_i),
        .in_valid_i  (s_axis_in_tvalid_i),
        .win_beat_o  (win_beat),
        .win_valid_o (win_valid)
    );

    fft_core #(
        .NFFT (NFFT)
    ) u_fft_core (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .win_beat_i  (win_beat),
        .win_valid_i (win_valid),
        .bin_beat_o  (bin_beat),
        .bin_valid_o (bin_valid)
    );

    symbol_tagger #(
        .NFFT (NFFT)
    ) u_symbol_tagger (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .ssb_start_i (ssb_start_i),
        .bin_beat_i  (bin_beat),
        .bin_valid_i (bin_valid),
        .out_data_o  (m_axis_out_tdata_o),
        .out_valid_o (m_axis_out_tvalid_o),
        .flags_o     (flags_o)
    );

endmodule

/* dv/ssb_demod_ref.svh */
`ifndef SSB_DEMOD_REF_SVH
`define SSB_DEMOD_REF_SVH

localparam real TWO_PI = 6.283185307179586;

// one bin of the DFT of windows[sym], divided by the FFT length and rounded
// uses FFT_LEN and windows of the including module
function automatic ssb_demod_pkg::cplx_t dft_bin(input int sym, input int k);
    real                  acc_re;
    real                  acc_im;
    real                  ang;
    real                  x_re;
    real                  x_im;
    int                   n;
    int                   re_v;
    int                   im_v;
    ssb_demod_pkg::cplx_t res;
    acc_re = 0.0;
    acc_im = 0.0;
    for (n = 0; n < FFT_LEN; n++) begin
        // reduce k*n first so the angle stays exact
        ang    = -TWO_PI * real'((k * n) % FFT_LEN) / real'(FFT_LEN);
        x_re   = real'(windows[sym][n].re);
        x_im   = real'(windows[sym][n].im);
        acc_re = acc_re + x_re * $cos(ang) - x_im * $sin(ang);
        acc_im = acc_im + x_re * $sin(ang) + x_im * $cos(ang);
    end
    re_v   = int'(acc_re / real'(FFT_LEN));
    im_v   = int'(acc_im / real'(FFT_LEN));
    res.re = re_v[ssb_demod_pkg::SAMPLE_W-1:0];
    res.im = im_v[ssb_demod_pkg::SAMPLE_W-1:0];
    return res;
endfunction

`endif

/* dv/ssb_demod_tb.sv */
`timescale 1ns/10ps

module ssb_demod_tb;

    localparam int NFFT = 8;
    localparam int CP_LEN = 18;
    localparam int FFT_LEN = 2 ** NFFT;
    localparam int NSYM = ssb_demod_pkg::SSB_SYMBOLS;
    localparam int FLAG_SLOT = NSYM;
    localparam int IMPULSE_AMP = 16384;
    localparam int TONE_BIN = 5;
    localparam real TONE_AMP = 8000.0;
    localparam int DATA_SPAN = 8000;
    localparam int CP_SPAN = 32767;
    localparam int DRAIN_TIMEOUT = 5000;

    logic                      clk_i = 1'b0;
    logic                      reset_ni;
    logic                      ssb_start_i;
    ssb_demod_pkg::cplx_t      s_axis_in_tdata_i;
    logic                      s_axis_in_tvalid_i;
    ssb_demod_pkg::cplx_t      m_axis_out_tdata_o;
    logic                      m_axis_out_tvalid_o;
    ssb_demod_pkg::ssb_flags_t flags_o;

    // stimulus of the current SSB for the expected values
    ssb_demod_pkg::cplx_t windows [NSYM][FFT_LEN];
    ssb_demod_pkg::cplx_t prefixes [NSYM-1][CP_LEN];

    int out_sym = 0;
    int out_bin = 0;
    int sym_done = 0;
    bit expect_out = 1'b0;
    bit timed_out = 1'b0;
    // value errors per symbol plus one slot for flags and framing
    int slot_err [NSYM+1] = '{default: 0};
    int err_cnt = 0;
    int check_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "ssb_demod_ref.svh"

    ssb_demod_top #(
        .NFFT   (NFFT),
        .CP_LEN (CP_LEN)
    ) uut (
        .clk_i               (clk_i),
        .reset_ni            (reset_ni),
        .s_axis_in_tdata_i   (s_axis_in_tdata_i),
        .s_axis_in_tvalid_i  (s_axis_in_tvalid_i),
        .ssb_start_i         (ssb_start_i),
        .m_axis_out_tdata_o  (m_axis_out_tdata_o),
        .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
        .flags_o             (flags_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic ssb_demod_pkg::cplx_t make_cplx(input int re_v, input int im_v);
        ssb_demod_pkg::cplx_t s;
        s.re = re_v[ssb_demod_pkg::SAMPLE_W-1:0];
        s.im = im_v[ssb_demod_pkg::SAMPLE_W-1:0];
        return s;
    endfunction

    function automatic ssb_demod_pkg::cplx_t random_sample(input int span);
        int re_v;
        int im_v;
        re_v = int'($urandom % (2 * span + 1)) - span;
        im_v = int'($urandom % (2 * span + 1)) - span;
        return make_cplx(re_v, im_v);
    endfunction

    function automatic bit within_tol(input int got, input int want);
        return (got - want <= NFFT) && (want - got <= NFFT);
    endfunction

    // flat spectrum for the impulse and a single line for the tone
    function automatic ssb_demod_pkg::cplx_t expected_bin(input int sym, input int k);
        if (sym == 0) begin
            return make_cplx(IMPULSE_AMP / FFT_LEN, 0);
        end else if (sym == 1 && k != TONE_BIN) begin
            return make_cplx(0, 0);
        end else begin
            return dft_bin(sym, k);
        end
    endfunction

    // symbol 0 impulse, symbol 1 tone, symbols 2 and 3 random
    task automatic build_ssb();
        int  n;
        int  s;
        int  c;
        real ang;
        for (n = 0; n < FFT_LEN; n++) begin
            windows[0][n] = make_cplx((n == 0) ? IMPULSE_AMP : 0, 0);
            ang = TWO_PI * real'((TONE_BIN * n) % FFT_LEN) / real'(FFT_LEN);
            windows[1][n] = make_cplx(int'(TONE_AMP * $cos(ang)), int'(TONE_AMP * $sin(ang)));
            for (s = 2; s < NSYM; s++) begin
                windows[s][n] = random_sample(DATA_SPAN);
            end
        end
        for (s = 0; s < NSYM - 1; s++) begin
            for (c = 0; c < CP_LEN; c++) begin
                prefixes[s][c] = random_sample(CP_SPAN);
            end
        end
    endtask

    // one valid sample every 8 cycles
    task automatic drive_sample(input ssb_demod_pkg::cplx_t s);
        s_axis_in_tdata_i  = s;
        s_axis_in_tvalid_i = 1'b1;
        @(posedge clk_i);
        #2;
        s_axis_in_tvalid_i = 1'b0;
        repeat (7) @(posedge clk_i);
        #2;
    endtask

    task automatic log_error(input int slot);
        slot_err[slot]++;
        err_cnt++;
    endtask

    task automatic report_value_mismatch(input string sig, input int got, input int want);
        $display("Mismatch at %0d ns: %s sym %0d bin %0d got %0d expected %0d",
                 $time, sig, out_sym, out_bin, got, want);
        log_error(out_sym);
    endtask

    task automatic close_symbol();
        out_bin = 0;
        out_sym++;
        sym_done = out_sym;
        if (out_sym == NSYM) begin
            expect_out = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
    endtask

    task automatic finish_run();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic check_bin();
        ssb_demod_pkg::cplx_t      want;
        ssb_demod_pkg::ssb_flags_t want_flags;
        check_cnt++;
        assert (expect_out)
        else begin
            $display("Error at %0d ns: output bin appeared while no symbol was due", $time);
            log_error(FLAG_SLOT);
        end
        if (expect_out) begin
            want = expected_bin(out_sym, out_bin);
            want_flags.pbch_start   = (out_sym == 0) && (out_bin == 0);
            want_flags.pbch_valid   = (out_sym == 0);
            want_flags.sss_start    = (out_sym == 1) && (out_bin == 0);
            want_flags.sss_valid    = (out_sym == 1);
            want_flags.symbol_start = (out_bin == 0);
            check_cnt += 3;
            assert (!$isunknown(m_axis_out_tdata_o.re)
                    && within_tol(m_axis_out_tdata_o.re, want.re))
            else begin
                report_value_mismatch("m_axis_out_tdata_o.re", m_axis_out_tdata_o.re, want.re);
            end
            assert (!$isunknown(m_axis_out_tdata_o.im)
                    && within_tol(m_axis_out_tdata_o.im, want.im))
            else begin
                report_value_mismatch("m_axis_out_tdata_o.im", m_axis_out_tdata_o.im, want.im);
            end
            // field order pbch_start pbch_valid sss_start sss_valid symbol_start
            assert (flags_o === want_flags)
            else begin
                $display("Mismatch at %0d ns: flags_o sym %0d bin %0d got %05b expected %05b",
                         $time, out_sym, out_bin, flags_o, want_flags);
                log_error(FLAG_SLOT);
            end
            out_bin++;
            if (out_bin == FFT_LEN) begin
                close_symbol();
            end
        end
    endtask

    task automatic check_idle();
        check_cnt += 2;
        assert (m_axis_out_tvalid_o === 1'b0 && flags_o === '0)
        else begin
            $display("Error at %0d ns: output valid or flags not low outside a bin", $time);
            log_error(FLAG_SLOT);
        end
        assert (out_bin == 0)
        else begin
            $display("Error at %0d ns: gap in the bins of symbol %0d after bin %0d",
                     $time, out_sym, out_bin);
            log_error(FLAG_SLOT);
            close_symbol();
        end
    endtask

    // compare process sampling away from the rising edge
    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (m_axis_out_tvalid_o === 1'b1) begin
                check_bin();
            end else begin
                check_idle();
            end
        end
    end

    task automatic wait_symbols_done();
        int n;
        n = 0;
        while (sym_done < NSYM && n < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        #2;
        if (sym_done < NSYM) begin
            $display("Timeout: only %0d of %0d symbols came out of the DUT", sym_done, NSYM);
            log_error(FLAG_SLOT);
            timed_out = 1'b1;
        end
    endtask

    // pulse and bare first window followed by prefix and window per symbol
    task automatic run_ssb();
        int s;
        int c;
        int n;
        build_ssb();
        out_sym  = 0;
        out_bin  = 0;
        sym_done = 0;
        for (s = 0; s <= NSYM; s++) begin
            slot_err[s] = 0;
        end
        expect_out  = 1'b1;
        ssb_start_i = 1'b1;
        @(posedge clk_i);
        #2;
        ssb_start_i = 1'b0;
        for (s = 0; s < NSYM; s++) begin
            if (s > 0) begin
                for (c = 0; c < CP_LEN; c++) begin
                    drive_sample(prefixes[s-1][c]);
                end
            end
            for (n = 0; n < FFT_LEN; n++) begin
                drive_sample(windows[s][n]);
            end
        end
        wait_symbols_done();
    endtask

    initial begin
        int snap;
        void'($urandom(32'hf47e845b));
        reset_ni           = 1'b0;
        ssb_start_i        = 1'b0;
        s_axis_in_tvalid_i = 1'b0;
        s_axis_in_tdata_i  = '0;
        repeat (16) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        snap = err_cnt;
        repeat (200) @(posedge clk_i);
        #2;
        report_test("reset", err_cnt - snap);

        run_ssb();
        report_test("impulse", slot_err[0]);
        report_test("tone", slot_err[1]);
        report_test("random with cp", slot_err[2] + slot_err[3]);
        report_test("flags", slot_err[FLAG_SLOT]);

        if (!timed_out) begin
            // nothing may come out between the two SSBs
            snap = err_cnt;
            repeat (300) @(posedge clk_i);
            #2;
            run_ssb();
            report_test("second ssb", err_cnt - snap);
        end
        finish_run();
    end

endmodule

/* ssb_demod.f */
+incdir+dv
verilog/ssb_demod_pkg.sv
verilog/cp_remover.sv
verilog/fft_butterfly.sv
verilog/fft_core.sv
verilog/symbol_tagger.sv
verilog/ssb_demod_top.sv
dv/ssb_demod_tb.sv

/* Bender.yml */
package:
  name: ssb_demod

sources:
  - verilog/ssb_demod_pkg.sv
  - verilog/cp_remover.sv
  - verilog/fft_butterfly.sv
  - verilog/fft_core.sv
  - verilog/symbol_tagger.sv
  - verilog/ssb_demod_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ssb_demod_tb.sv
